// ==== rtl/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes of the kept groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2
    } alu_op_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef struct packed {
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_uv_t;

    // one instruction word, read as r, i or u format
    typedef union packed {
        inst_r_t  r;
        inst_i_t  i;
        inst_uv_t u;
    } inst_u;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        alu_op_e               alu_op;
        op2_sel_e              op2_sel;
        logic                  uses_rs1;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] imm;
    } ex_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

// ==== rtl/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode (
    input  core_pkg::inst_u inst_i,
    output core_pkg::ctrl_t ctrl_o
);

    logic              f7_zero;
    logic              f7_alt;
    core_pkg::alu_op_e f3_op;

    assign f7_zero = (inst_i.r.funct7 == 7'b0000000);
    assign f7_alt  = (inst_i.r.funct7 == 7'b0100000);

    // funct3 gives the operation, funct7 only picks sub/sra
    always_comb begin
        case (inst_i.r.funct3)
            3'b000:  f3_op = core_pkg::ALU_ADD;
            3'b001:  f3_op = core_pkg::ALU_SLL;
            3'b010:  f3_op = core_pkg::ALU_SLT;
            3'b011:  f3_op = core_pkg::ALU_SLTU;
            3'b100:  f3_op = core_pkg::ALU_XOR;
            3'b101:  f3_op = inst_i.r.funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  f3_op = core_pkg::ALU_OR;
            default: f3_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o    = '0;
        ctrl_o.rd = inst_i.r.rd;
        case (inst_i.r.opcode)
            core_pkg::OPC_OP: begin
                ctrl_o.valid    = f7_zero ||
                                  (f7_alt && (inst_i.r.funct3 == 3'b000 ||
                                              inst_i.r.funct3 == 3'b101));
                ctrl_o.rs1      = inst_i.r.rs1;
                ctrl_o.rs2      = inst_i.r.rs2;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.op2_sel  = core_pkg::OP2_RS2;
                ctrl_o.alu_op   = (inst_i.r.funct3 == 3'b000 && inst_i.r.funct7[5]) ?
                                  core_pkg::ALU_SUB : f3_op;
            end
            core_pkg::OPC_OP_IMM: begin
                // upper imm bits only matter for the shifts
                case (inst_i.r.funct3)
                    3'b001:  ctrl_o.valid = f7_zero;
                    3'b101:  ctrl_o.valid = f7_zero || f7_alt;
                    default: ctrl_o.valid = 1'b1;
                endcase
                ctrl_o.rs1      = inst_i.r.rs1;
                ctrl_o.uses_rs1 = 1'b1;
                ctrl_o.op2_sel  = core_pkg::OP2_IMM;
                ctrl_o.alu_op   = f3_op;
            end
            core_pkg::OPC_LUI: begin
                ctrl_o.valid   = 1'b1;
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                ctrl_o.alu_op  = core_pkg::ALU_PASS2;
            end
            default: ctrl_o.valid = 1'b0;
        endcase
    end

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/10ps

module imm_gen (
    input  core_pkg::inst_u              inst_i,
    output logic [core_pkg::XLEN-1:0]    imm_o
);

    logic is_shift_imm;

    // slli, srli and srai carry a shift amount, not a signed value
    assign is_shift_imm = (inst_i.i.opcode == core_pkg::OPC_OP_IMM) &&
                          (inst_i.i.funct3[1:0] == 2'b01);

    always_comb begin
        if (inst_i.u.opcode == core_pkg::OPC_LUI) begin
            imm_o = {inst_i.u.imm20, 12'b0};
        end else if (is_shift_imm) begin
            imm_o = {27'b0, inst_i.i.imm12[4:0]};
        end else begin
            imm_o = {{(core_pkg::XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]    rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]    rs2_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]    rd_i,
    input  logic [core_pkg::XLEN-1:0]          wdata_i,
    input  logic                               we_i,
    output logic [core_pkg::XLEN-1:0]          rdata1_o,
    output logic [core_pkg::XLEN-1:0]          rdata2_o
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== rtl/operand_select.sv ====
`timescale 1ns/10ps

module operand_select (
    input  core_pkg::ctrl_t                    ctrl_i,
    input  logic [core_pkg::XLEN-1:0]          imm_i,
    input  logic [core_pkg::XLEN-1:0]          rdata1_i,
    input  logic [core_pkg::XLEN-1:0]          rdata2_i,
    input  core_pkg::fwd_t                     ex_fwd_i,
    input  core_pkg::fwd_t                     wb_fwd_i,
    output logic [core_pkg::REG_ADDR_W-1:0]    rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0]    rs2_o,
    output core_pkg::ex_t                      ex_o
);

    logic [core_pkg::XLEN-1:0] rs1_val;
    logic [core_pkg::XLEN-1:0] rs2_val;

    // EX is checked before WB and WB before the register file
    function automatic logic [core_pkg::XLEN-1:0] bypass(
        input logic [core_pkg::REG_ADDR_W-1:0] addr,
        input logic [core_pkg::XLEN-1:0]       rdata,
        input core_pkg::fwd_t                  ex_fwd,
        input core_pkg::fwd_t                  wb_fwd
    );
        logic [core_pkg::XLEN-1:0] val;
        val = rdata;
        if (addr != '0) begin
            if (ex_fwd.valid && ex_fwd.rd == addr) begin
                val = ex_fwd.data;
            end else if (wb_fwd.valid && wb_fwd.rd == addr) begin
                val = wb_fwd.data;
            end
        end
        return val;
    endfunction

    assign rs1_o = ctrl_i.rs1;
    assign rs2_o = ctrl_i.rs2;

    assign rs1_val = bypass(ctrl_i.rs1, rdata1_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val = bypass(ctrl_i.rs2, rdata2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        ex_o.ctrl = ctrl_i;
        ex_o.imm  = imm_i;
        // lui has no rs1
        ex_o.op1  = ctrl_i.uses_rs1 ? rs1_val : '0;
        if (ctrl_i.op2_sel == core_pkg::OP2_IMM) begin
            ex_o.op2 = imm_i;
        end else begin
            ex_o.op2 = rs2_val;
        end
    end

endmodule

// ==== rtl/alu_exec.sv ====
`timescale 1ns/10ps

module alu_exec (
    input  core_pkg::ex_t                  ex_i,
    output logic [core_pkg::XLEN-1:0]      result_o
);

    logic [core_pkg::XLEN-1:0] a;
    logic [core_pkg::XLEN-1:0] b;
    logic [4:0]                shamt;

    assign a     = ex_i.op1;
    assign b     = ex_i.op2;
    assign shamt = b[4:0];

    always_comb begin
        case (ex_i.ctrl.alu_op)
            core_pkg::ALU_ADD:  result_o = a + b;
            core_pkg::ALU_SUB:  result_o = a - b;
            core_pkg::ALU_SLL:  result_o = a << shamt;
            core_pkg::ALU_SLT: begin
                result_o = {31'b0, $signed(a) < $signed(b)};
            end
            core_pkg::ALU_SLTU: begin
                result_o = {31'b0, a < b};
            end
            core_pkg::ALU_XOR:  result_o = a ^ b;
            core_pkg::ALU_SRL:  result_o = a >> shamt;
            core_pkg::ALU_SRA:  result_o = $unsigned($signed(a) >>> shamt);
            core_pkg::ALU_OR:   result_o = a | b;
            core_pkg::ALU_AND:  result_o = a & b;
            // lui writes the upper immediate as is
            core_pkg::ALU_PASS2: result_o = ex_i.imm;
            default:            result_o = '0;
        endcase
    end

endmodule

// ==== rtl/alu_core.sv ====
`timescale 1ns/10ps

module alu_core (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              inst_valid_i,
    input  core_pkg::inst_u   inst_i,
    output logic              inst_ready_o,
    output logic              retire_valid_o,
    output core_pkg::retire_t retire_o,
    input  logic              retire_ready_i
);

    logic stall;

    logic            id_valid;
    core_pkg::inst_u id_inst;

    core_pkg::ctrl_t                     id_ctrl;
    logic [core_pkg::XLEN-1:0]           id_imm;
    logic [core_pkg::REG_ADDR_W-1:0]     rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0]     rs2_addr;
    logic [core_pkg::XLEN-1:0]           rdata1;
    logic [core_pkg::XLEN-1:0]           rdata2;
    core_pkg::ex_t                       ex_sel;
    core_pkg::ex_t                       ex_d;
    core_pkg::ex_t                       ex_q;
    logic [core_pkg::XLEN-1:0]           ex_result;

    logic              wb_valid;
    core_pkg::retire_t wb_q;

    core_pkg::fwd_t ex_fwd;
    core_pkg::fwd_t wb_fwd;

    // retire back-pressure is the only stall
    assign stall        = retire_valid_o && !retire_ready_i;
    assign inst_ready_o = !stall;

    // ID stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && inst_valid_i) begin
            id_inst <= inst_i;
        end
    end

    inst_decode u_inst_decode (
        .inst_i (id_inst),
        .ctrl_o (id_ctrl)
    );

    imm_gen u_imm_gen (
        .inst_i (id_inst),
        .imm_o  (id_imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rs1_i    (rs1_addr),
        .rs2_i    (rs2_addr),
        .rd_i     (wb_q.rd),
        .wdata_i  (wb_q.data),
        .we_i     (retire_valid_o && retire_ready_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_select u_operand_select (
        .ctrl_i   (id_ctrl),
        .imm_i    (id_imm),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .ex_fwd_i (ex_fwd),
        .wb_fwd_i (wb_fwd),
        .rs1_o    (rs1_addr),
        .rs2_o    (rs2_addr),
        .ex_o     (ex_sel)
    );

    // an empty ID or an illegal word moves on as a bubble
    always_comb begin
        ex_d            = ex_sel;
        ex_d.ctrl.valid = id_valid && ex_sel.ctrl.valid;
    end

    // EX stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_q <= '0;
        end else if (!stall) begin
            ex_q <= ex_d;
        end
    end

    alu_exec u_alu_exec (
        .ex_i     (ex_q),
        .result_o (ex_result)
    );

    assign ex_fwd.valid = ex_q.ctrl.valid;
    assign ex_fwd.rd    = ex_q.ctrl.rd;
    assign ex_fwd.data  = ex_result;

    // WB stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= ex_q.ctrl.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_q.rd   <= ex_q.ctrl.rd;
            wb_q.data <= ex_result;
        end
    end

    assign wb_fwd.valid = wb_valid;
    assign wb_fwd.rd    = wb_q.rd;
    assign wb_fwd.data  = wb_q.data;

    assign retire_valid_o = wb_valid;
    assign retire_o       = wb_q;

endmodule

// ==== verification/alu_core_props.sv ====
`timescale 1ns/10ps

module alu_core_props (
    input logic              clk,
    input logic              arst_n_i,
    input logic              inst_ready_o,
    input logic              retire_valid_o,
    input logic              retire_ready_i,
    input core_pkg::retire_t retire_o
);

    // a stalled result stays put until it is taken
    property retire_held;
        @(posedge clk) disable iff (!arst_n_i)
            (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_o));
    endproperty

    property ready_follows_stall;
        @(posedge clk) disable iff (!arst_n_i)
            inst_ready_o == !(retire_valid_o && !retire_ready_i);
    endproperty

    a_retire_held: assert property (retire_held)
        else $error("retire port changed while stalled");
    a_ready_follows_stall: assert property (ready_follows_stall)
        else $error("inst_ready_o does not match the retire stall");
    a_reset_quiet: assert property (@(posedge clk) !arst_n_i |-> !retire_valid_o)
        else $error("retire_valid_o high during reset");

endmodule

bind alu_core alu_core_props u_props (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .inst_ready_o   (inst_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
);

// ==== verification/alu_core_tb.sv ====
`timescale 1ns/10ps

module alu_core_tb;

    // upper bound on instructions issued by all tests for the watchdog
    localparam int MAX_INSTS = 200;

    logic              clk;
    logic              arst_n_i;
    logic              inst_valid_i;
    core_pkg::inst_u   inst_i;
    logic              inst_ready_o;
    logic              retire_valid_o;
    core_pkg::retire_t retire_o;
    logic              retire_ready_i;

    logic [31:0]       model_regs [0:31];
    core_pkg::retire_t exp_q [$];
    logic [31:0]       seed;
    logic              bp_on;
    logic [15:0]       bp_pattern;
    int                bp_cycle;
    int                errors;
    int                checks;
    int                issued;
    int                stalls;
    int                test_count;
    int                test_err_start;

    alu_core uut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, actual,
                     expected);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] op_rr(input logic [2:0] f3, input logic [6:0] f7,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] op_ri(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] op_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, core_pkg::OPC_LUI};
    endfunction

    // ISA reference model that returns 0 outside the kept groups
    function automatic logic model_exec(input logic [31:0] w, output logic [31:0] res);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        res = '0;
        if (opc == core_pkg::OPC_LUI) begin
            res = {w[31:12], 12'b0};
            return 1'b1;
        end
        if (opc == core_pkg::OPC_OP_IMM) begin
            if (f3 == 3'b001 && f7 != 7'h00) return 1'b0;
            if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) return 1'b0;
            b = {{20{w[31]}}, w[31:20]};
        end else if (opc == core_pkg::OPC_OP) begin
            if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) return 1'b0;
        end else begin
            return 1'b0;
        end
        case (f3)
            3'b000:  res = (opc == core_pkg::OPC_OP && f7[5]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b101:  res = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return 1'b1;
    endfunction

    // registers x0..x(mask) only so random sequences stay dependent
    function automatic logic [31:0] rand_kept(input logic [4:0] mask);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = lcg_next();
        f3 = r[2:0];
        f7 = (r[18] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        case (r[20:19])
            2'd0: return op_lui(r[7:3] & mask, r[31:12]);
            2'd1: return op_rr(f3, f7, r[7:3] & mask, r[12:8] & mask, r[17:13] & mask);
            default: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    return op_ri(f3, r[7:3] & mask, r[12:8] & mask, {f7, r[25:21]});
                end
                return op_ri(f3, r[7:3] & mask, r[12:8] & mask, r[31:20]);
            end
        endcase
    endfunction

    function automatic logic [31:0] rand_bad(input logic [31:0] r);
        case (r[4:3])
            2'd0:    return {r[31:7], 7'b0000011};
            2'd1:    return {r[31:7], 7'b1100011};
            2'd2:    return op_rr(r[7:5], 7'h01, r[12:8], r[17:13], r[22:18]);
            default: return op_ri(3'b001, r[12:8], r[17:13], {7'h20, r[27:23]});
        endcase
    endfunction

    task automatic issue(input logic [31:0] word);
        logic              accepted;
        logic [31:0]       res;
        core_pkg::retire_t e;
        inst_valid_i = 1'b1;
        inst_i       = word;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready_o;
            @(posedge clk);
        end
        #2;
        inst_valid_i = 1'b0;
        issued++;
        if (model_exec(word, res)) begin
            e.rd   = word[11:7];
            e.data = res;
            exp_q.push_back(e);
            if (word[11:7] != 5'd0) model_regs[word[11:7]] = res;
        end
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        issue(op_lui(rd, upper[31:12]));
        issue(op_ri(3'b000, rd, rd, value[11:0]));
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, errors - test_err_start);
        test_err_start = errors;
    endtask

    // retire monitor sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n_i && retire_valid_o && retire_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0t ns: a result retired with none outstanding", $time);
            end else begin
                compare(retire_o, exp_q.pop_front(), "retire rd/data");
            end
        end
        if (arst_n_i && retire_valid_o && !retire_ready_i) begin
            stalls++;
            compare(inst_ready_o, 1'b0, "inst_ready_o while stalled");
        end
    end

    always @(posedge clk) begin
        #2;
        retire_ready_i = bp_on ? bp_pattern[bp_cycle % 16] : 1'b1;
        bp_cycle++;
    end

    task automatic test_after_reset();
        compare(retire_valid_o, 1'b0, "retire_valid_o after reset");
        compare(inst_ready_o, 1'b1, "inst_ready_o after reset");
        for (int r = 0; r < 32; r++) begin
            issue(op_ri(3'b000, r[4:0], r[4:0], 12'd0));
        end
        wait_idle();
        end_test("reset state");
    endtask

    task automatic test_each_op();
        load_const(5'd1, 32'h8000_1a34);
        load_const(5'd2, 32'h0000_0025);
        load_const(5'd3, 32'h0000_0007);
        issue(op_rr(3'b000, 7'h00, 5'd4, 5'd1, 5'd3));
        issue(op_rr(3'b000, 7'h20, 5'd5, 5'd3, 5'd1));
        issue(op_rr(3'b001, 7'h00, 5'd6, 5'd1, 5'd2));
        issue(op_rr(3'b010, 7'h00, 5'd7, 5'd1, 5'd3));
        issue(op_rr(3'b011, 7'h00, 5'd8, 5'd1, 5'd3));
        issue(op_rr(3'b100, 7'h00, 5'd9, 5'd1, 5'd3));
        issue(op_rr(3'b101, 7'h00, 5'd10, 5'd1, 5'd2));
        issue(op_rr(3'b101, 7'h20, 5'd11, 5'd1, 5'd2));
        issue(op_rr(3'b110, 7'h00, 5'd12, 5'd1, 5'd3));
        issue(op_rr(3'b111, 7'h00, 5'd13, 5'd1, 5'd2));
        issue(op_ri(3'b000, 5'd14, 5'd1, 12'hffb));
        issue(op_ri(3'b010, 5'd15, 5'd1, 12'h001));
        issue(op_ri(3'b011, 5'd16, 5'd3, 12'hfff));
        issue(op_ri(3'b100, 5'd17, 5'd1, 12'hfff));
        issue(op_ri(3'b110, 5'd18, 5'd3, 12'h700));
        issue(op_ri(3'b111, 5'd19, 5'd1, 12'h0ff));
        issue(op_ri(3'b001, 5'd20, 5'd3, 12'h01f));
        issue(op_ri(3'b101, 5'd21, 5'd1, 12'h004));
        issue(op_ri(3'b101, 5'd22, 5'd1, 12'h404));
        issue(op_lui(5'd23, 20'h12345));
        wait_idle();
        end_test("each operation");
    endtask

    task automatic test_forwarding();
        // distance 1 with the consumer right behind its producer
        issue(op_ri(3'b000, 5'd5, 5'd0, 12'd1));
        for (int k = 0; k < 3; k++) begin
            issue(op_rr(3'b000, 7'h00, 5'd5, 5'd5, 5'd5));
        end
        // distance 2 and 3 with one or two fillers in between
        issue(op_ri(3'b000, 5'd6, 5'd0, 12'h123));
        issue(op_ri(3'b000, 5'd9, 5'd0, 12'h7ff));
        issue(op_rr(3'b000, 7'h20, 5'd6, 5'd6, 5'd5));
        issue(op_lui(5'd7, 20'habcde));
        issue(op_ri(3'b100, 5'd10, 5'd9, 12'hfff));
        issue(op_ri(3'b110, 5'd11, 5'd0, 12'h0f0));
        issue(op_rr(3'b100, 7'h00, 5'd12, 5'd7, 5'd6));
        wait_idle();
        end_test("forwarding chains");
    endtask

    task automatic test_x0_writes();
        issue(op_ri(3'b000, 5'd0, 5'd1, 12'h055));
        issue(op_rr(3'b000, 7'h00, 5'd13, 5'd0, 5'd0));
        issue(op_ri(3'b110, 5'd0, 5'd0, 12'hfff));
        issue(op_lui(5'd0, 20'hfffff));
        issue(op_ri(3'b000, 5'd14, 5'd0, 12'd0));
        issue(op_rr(3'b110, 7'h00, 5'd15, 5'd0, 5'd0));
        wait_idle();
        end_test("x0 writes");
    endtask

    task automatic test_backpressure();
        stalls = 0;
        bp_on  = 1'b1;
        for (int k = 0; k < 20; k++) begin
            issue(rand_kept(5'h03));
        end
        wait_idle();
        bp_on = 1'b0;
        compare(stalls > 0, 1'b1, "stall cycles seen with back-pressure");
        end_test("retire back-pressure");
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        for (int k = 0; k < 60; k++) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                issue(rand_bad(r));
            end else begin
                issue(rand_kept(5'h07));
            end
        end
        wait_idle();
        end_test("random mix with bad opcodes");
    endtask

    initial begin
        #(MAX_INSTS * 40 * 20 + 4000);
        $display("timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        seed           = 32'd43985;
        bp_on          = 1'b0;
        bp_pattern     = 16'b1011_0011_1000_1101;
        bp_cycle       = 0;
        errors         = 0;
        checks         = 0;
        issued         = 0;
        stalls         = 0;
        test_count     = 0;
        test_err_start = 0;
        arst_n_i       = 1'b0;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        retire_ready_i = 1'b1;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        test_after_reset();
        test_each_op();
        test_forwarding();
        test_x0_writes();
        test_backpressure();
        test_random_mix();
        $display("tests: %0d, instructions: %0d, checks: %0d, errors: %0d",
                 test_count, issued, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/operand_select.sv
rtl/alu_exec.sv
rtl/alu_core.sv
verification/alu_core_props.sv
verification/alu_core_tb.sv
